//--- verilog/fp4_pkg.sv
// fp4 package
// complex FP4 (E2M1) sample types, transform sizes and the conversions
// between E2M1 codes and signed quarter-unit integers
package fp4_pkg;

    typedef logic [3:0] fp4_t;                  // sign, 3-bit magnitude code
    typedef logic [7:0] cfp4_t;                 // real in [7:4], imag in [3:0]

    localparam int MAX_N  = 32;                 // largest transform size
    localparam int ADDR_W = $clog2(MAX_N);      // sample ram address width
    localparam int CNT_W  = ADDR_W + 1;         // wide enough to hold MAX_N itself

    localparam int Q_W = 12;                    // quarter-unit work width
    typedef logic signed [Q_W-1:0] q_t;

    // E2M1 code to quarter units (0, 0.5, 1, 1.5, 2, 3, 4, 6)
    function automatic logic signed [7:0] fp4_to_q(input fp4_t v);
        logic signed [7:0] mag;
        case (v[2:0])
            3'd0:    mag = 8'sd0;
            3'd1:    mag = 8'sd2;
            3'd2:    mag = 8'sd4;
            3'd3:    mag = 8'sd6;
            3'd4:    mag = 8'sd8;
            3'd5:    mag = 8'sd12;
            3'd6:    mag = 8'sd16;
            default: mag = 8'sd24;
        endcase
        fp4_to_q = v[3] ? -mag : mag;
    endfunction

    // quarter units back to E2M1, nearest value, ties to the even code
    // thresholds are the tie points: 1->0, 3->2, 5->2, 7->4, 10->4, 14->6, 20->6
    function automatic fp4_t q_to_fp4(input q_t q);
        q_t         mag;
        logic [2:0] code;
        mag = q[Q_W-1] ? -q : q;
        if (mag >= 21)      code = 3'd7;        // 21 and above saturate at 6
        else if (mag >= 14) code = 3'd6;
        else if (mag >= 11) code = 3'd5;
        else if (mag >= 7)  code = 3'd4;
        else if (mag >= 6)  code = 3'd3;
        else if (mag >= 3)  code = 3'd2;
        else if (mag >= 2)  code = 3'd1;
        else                code = 3'd0;
        q_to_fp4 = {q[Q_W-1] && (code != 3'd0), code}; // no negative zero
    endfunction

endpackage

//--- verilog/twiddle_rom.sv
// twiddle table
// returns the quantized complex factor W^idx for an N-point transform,
// scaling the index onto the MAX_N-entry circle with shifts
`timescale 1ns/100ps

module twiddle_rom
    import fp4_pkg::*;
#(
    parameter int MAX_N = fp4_pkg::MAX_N
) (
    input  logic [ADDR_W-1:0] tw_idx,
    input  logic [CNT_W-1:0]  n_reg,
    output cfp4_t             twiddle
);

    localparam int LOG_MAX = $clog2(MAX_N);

    logic [ADDR_W-1:0] scaled;                  // index on the full circle
    cfp4_t             base;                    // first-octant entry

    // negate one part, zero keeps a clear sign
    function automatic fp4_t neg(input fp4_t v);
        neg = (v[2:0] == 3'd0) ? 4'b0000 : {~v[3], v[2:0]};
    endfunction

    always_comb begin
        scaled = '0;                            // invalid N maps to W^0
        for (int i = 1; i <= LOG_MAX; i++) begin
            if (n_reg == CNT_W'(1 << i))
                scaled = ADDR_W'(tw_idx << (LOG_MAX - i)); // idx * MAX_N/N
        end
    end

    always_comb begin
        case (scaled[2:0])
            3'd0:    base = 8'b0010_0000;       // 1
            3'd1:    base = 8'b0010_0000;       // 1
            3'd2:    base = 8'b0010_1001;       // 1 - 0.5j
            3'd3:    base = 8'b0010_1001;       // 1 - 0.5j
            3'd4:    base = 8'b0001_1001;       // 0.5 - 0.5j
            3'd5:    base = 8'b0001_1010;       // 0.5 - j
            3'd6:    base = 8'b0001_1010;       // 0.5 - j
            default: base = 8'b0000_1010;       // -j
        endcase
    end

    // each group of 8 is the previous one times -j: (r, i) -> (i, -r)
    always_comb begin
        twiddle = base;
        for (int r = 0; r < 3; r++) begin
            if (r < scaled[ADDR_W-1:ADDR_W-2])
                twiddle = {twiddle[3:0], neg(twiddle[7:4])};
        end
    end

endmodule

//--- verilog/fp4_cmul.sv
// complex FP4 multiplier
// exact products in quarter units, one rounding per component
`timescale 1ns/100ps

module fp4_cmul
    import fp4_pkg::*;
(
    input  cfp4_t a,
    input  cfp4_t b,
    output cfp4_t p
);

    q_t ar, ai, br, bi;                         // operands in quarter units
    q_t re_full, im_full;                       // sums of products, 1/16 units

    assign ar = fp4_to_q(a[7:4]);
    assign ai = fp4_to_q(a[3:0]);
    assign br = fp4_to_q(b[7:4]);
    assign bi = fp4_to_q(b[3:0]);

    assign re_full = ar * br - ai * bi;         // ac - bd
    assign im_full = ar * bi + ai * br;         // ad + bc

    // every operand is a multiple of 0.5 so the shift back to quarters is exact
    assign p = {q_to_fp4(re_full >>> 2), q_to_fp4(im_full >>> 2)};

endmodule

//--- verilog/dft_mac.sv
// pipelined complex multiply-accumulate
// stage 1 registers the rounded product, stage 2 adds it into the bin sum
// the sum restarts on first and is presented with acc_valid after last
`timescale 1ns/100ps

module dft_mac
    import fp4_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  cfp4_t sample,
    input  cfp4_t twiddle,
    input  logic  in_valid,
    input  logic  first,
    input  logic  last,
    output cfp4_t acc,
    output logic  acc_valid
);

    cfp4_t prod;                                // combinational product
    cfp4_t prod_q;                              // stage 1 product
    cfp4_t sum_q;                               // running sum of the bin
    logic  prod_valid, prod_first, prod_last;
    q_t    base_re, base_im;
    q_t    add_re, add_im;

    fp4_cmul u_cmul (
        .a (sample),
        .b (twiddle),
        .p (prod)
    );

    always_ff @(posedge clk) begin
        prod_q <= prod;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            prod_valid <= 1'b0;
            prod_first <= 1'b0;
            prod_last  <= 1'b0;
            acc_valid  <= 1'b0;
        end else begin
            prod_valid <= in_valid;
            prod_first <= in_valid && first;
            prod_last  <= in_valid && last;
            acc_valid  <= prod_valid && prod_last; // sum of the bin is complete
        end
    end

    // new bin starts from zero instead of the old sum
    assign base_re = prod_first ? 8'sd0 : fp4_to_q(sum_q[7:4]);
    assign base_im = prod_first ? 8'sd0 : fp4_to_q(sum_q[3:0]);
    assign add_re  = base_re + fp4_to_q(prod_q[7:4]);
    assign add_im  = base_im + fp4_to_q(prod_q[3:0]);

    always_ff @(posedge clk) begin
        if (prod_valid)
            sum_q <= {q_to_fp4(add_re), q_to_fp4(add_im)}; // round after each add
    end

    assign acc = sum_q;

endmodule

//--- verilog/sample_ram.sv
// complex sample memory
// MAX_N words, synchronous write, registered read with one cycle latency
`timescale 1ns/100ps

module sample_ram
    import fp4_pkg::*;
#(
    parameter int MAX_N = fp4_pkg::MAX_N
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  cfp4_t             wdata,
    input  logic [ADDR_W-1:0] raddr,
    output cfp4_t             rdata
);

    cfp4_t mem [MAX_N];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];                    // old data on a same-address write
    end

endmodule

//--- verilog/dft_engine.sv
// DFT engine
// walks k and n at one input read per cycle, feeds each sample and its
// twiddle into the MAC and writes every finished X[k] to the result RAM
`timescale 1ns/100ps

module dft_engine
    import fp4_pkg::*;
#(
    parameter int MAX_N = fp4_pkg::MAX_N
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [CNT_W-1:0]  n_reg,
    output logic [ADDR_W-1:0] in_raddr,
    input  cfp4_t             in_rdata,
    output logic              out_we,
    output logic [ADDR_W-1:0] out_waddr,
    output cfp4_t             out_wdata,
    output logic              done
);

    logic              issuing;                 // reads still to issue
    logic              busy;                    // from start until the last write
    logic [ADDR_W-1:0] k, n;                    // bin and sample counters
    logic [ADDR_W-1:0] tw;                      // k*n mod N
    logic [ADDR_W-1:0] last_idx;                // N-1, also the modulo mask
    logic [ADDR_W-1:0] wptr;                    // bin of the next result
    logic              s1_valid, s1_first, s1_last;
    logic [ADDR_W-1:0] s1_tw;                   // twiddle index aligned with ram data
    cfp4_t             twiddle;
    cfp4_t             acc;
    logic              acc_valid;

    assign last_idx = ADDR_W'(n_reg - 1'b1);
    assign in_raddr = n;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            issuing  <= 1'b0;
            busy     <= 1'b0;
            k        <= '0;
            n        <= '0;
            tw       <= '0;
            wptr     <= '0;
            s1_valid <= 1'b0;
            s1_first <= 1'b0;
            s1_last  <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= issuing;                // ram data shows up next cycle
            s1_first <= issuing && (n == '0);
            s1_last  <= issuing && (n == last_idx);
            done     <= acc_valid && (wptr == last_idx);
            if (acc_valid)
                wptr <= wptr + 1'b1;
            if (acc_valid && (wptr == last_idx))
                busy <= 1'b0;
            if (start) begin
                issuing <= 1'b1;
                busy    <= 1'b1;
                k       <= '0;
                n       <= '0;
                tw      <= '0;
                wptr    <= '0;
            end else if (issuing) begin
                if (n == last_idx) begin        // bin done, next k
                    n  <= '0;
                    tw <= '0;
                    if (k == last_idx)
                        issuing <= 1'b0;        // N*N reads issued
                    else
                        k <= k + 1'b1;
                end else begin
                    n  <= n + 1'b1;
                    tw <= (tw + k) & last_idx;  // power-of-two N, mask is the modulo
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_tw <= tw;
    end

    twiddle_rom #(
        .MAX_N (MAX_N)
    ) u_twiddle_rom (
        .tw_idx  (s1_tw),
        .n_reg   (n_reg),
        .twiddle (twiddle)
    );

    dft_mac u_dft_mac (
        .clk       (clk),
        .rst       (rst),
        .sample    (in_rdata),
        .twiddle   (twiddle),
        .in_valid  (s1_valid),
        .first     (s1_first),
        .last      (s1_last),
        .acc       (acc),
        .acc_valid (acc_valid)
    );

    assign out_we    = acc_valid;
    assign out_waddr = wptr;
    assign out_wdata = acc;

    // results only come out of the MAC between start and the final write
    a_no_write_idle: assert property (@(posedge clk) disable iff (!rst) out_we |-> busy);

endmodule

//--- verilog/stream_ctrl.sv
// stream controller
// accepts N input samples, checks N on the first beat, starts the engine
// and streams the N results out of the result RAM after done
`timescale 1ns/100ps

module stream_ctrl
    import fp4_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [CNT_W-1:0]  n_points,
    input  cfp4_t             data_in,
    input  logic              data_in_valid,
    input  logic              done,
    output logic              dft_ready,
    output logic              error,
    output logic              start,
    output logic [CNT_W-1:0]  n_reg,
    output logic              in_we,
    output logic [ADDR_W-1:0] in_addr,
    output cfp4_t             in_wdata,
    output logic [ADDR_W-1:0] out_raddr,
    input  cfp4_t             out_rdata,
    output cfp4_t             data_out,
    output logic              data_out_valid
);

    typedef enum logic [1:0] {S_IDLE, S_LOAD, S_RUN, S_UNLOAD} state_t;

    state_t           state;
    logic [CNT_W-1:0] count;                    // samples accepted so far
    logic [CNT_W-1:0] rd_cnt;                   // result reads issued
    logic             accept;
    logic             n_ok;                     // power of two, 2..MAX_N
    logic             rd_issue;

    assign n_ok = (n_points >= CNT_W'(2)) && (n_points <= CNT_W'(MAX_N)) &&
                  ((n_points & (n_points - 1'b1)) == '0);

    assign dft_ready = (state == S_IDLE) || (state == S_LOAD);
    assign accept    = dft_ready && data_in_valid;
    assign in_we     = accept && ((state == S_LOAD) || n_ok); // bad N drops the beat
    assign in_addr   = count[ADDR_W-1:0];
    assign in_wdata  = data_in;

    // first read goes out on the done cycle so output starts right after it
    assign rd_issue  = ((state == S_RUN) && done) ||
                       ((state == S_UNLOAD) && (rd_cnt != n_reg));
    assign out_raddr = rd_cnt[ADDR_W-1:0];
    assign data_out  = out_rdata;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state          <= S_IDLE;
            count          <= '0;
            rd_cnt         <= '0;
            n_reg          <= '0;
            start          <= 1'b0;
            error          <= 1'b0;
            data_out_valid <= 1'b0;
        end else begin
            start          <= 1'b0;
            error          <= 1'b0;
            data_out_valid <= rd_issue;         // ram read latency of one
            if (rd_issue)
                rd_cnt <= rd_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    if (accept && n_ok) begin
                        n_reg <= n_points;
                        count <= count + 1'b1;
                        state <= S_LOAD;
                    end else if (accept) begin
                        error <= 1'b1;          // stay idle
                    end
                end
                S_LOAD: begin
                    if (accept) begin
                        count <= count + 1'b1;
                        if (count == n_reg - 1'b1) begin // Nth sample
                            count  <= '0;
                            rd_cnt <= '0;
                            start  <= 1'b1;
                            state  <= S_RUN;
                        end
                    end
                end
                S_RUN: begin
                    if (done)
                        state <= S_UNLOAD;
                end
                default: begin
                    if (rd_cnt == n_reg)
                        state <= S_IDLE;        // last beat is on the bus now
                end
            endcase
        end
    end

    // engine launches only after the sample for address N-1 was written
    a_start_on_load: assert property (@(posedge clk) disable iff (!rst)
        start |-> $past(in_we) && ($past(in_addr) == ADDR_W'(n_reg - 1'b1)));

endmodule

//--- verilog/fp4_dft.sv
// FP4 streaming DFT top level
// stream controller and DFT engine around an input and a result sample RAM
`timescale 1ns/100ps

module fp4_dft
    import fp4_pkg::*;
#(
    parameter int MAX_N = fp4_pkg::MAX_N
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [CNT_W-1:0] n_points,
    input  cfp4_t            data_in,
    input  logic             data_in_valid,
    output cfp4_t            data_out,
    output logic             data_out_valid,
    output logic             dft_ready,
    output logic             done,
    output logic             error
);

    logic              start;
    logic [CNT_W-1:0]  n_reg;
    logic              in_we;
    logic [ADDR_W-1:0] in_addr, in_raddr;
    cfp4_t             in_wdata, in_rdata;
    logic              out_we;
    logic [ADDR_W-1:0] out_waddr, out_raddr;
    cfp4_t             out_wdata, out_rdata;

    stream_ctrl u_stream_ctrl (
        .clk            (clk),
        .rst            (rst),
        .n_points       (n_points),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .done           (done),
        .dft_ready      (dft_ready),
        .error          (error),
        .start          (start),
        .n_reg          (n_reg),
        .in_we          (in_we),
        .in_addr        (in_addr),
        .in_wdata       (in_wdata),
        .out_raddr      (out_raddr),
        .out_rdata      (out_rdata),
        .data_out       (data_out),
        .data_out_valid (data_out_valid)
    );

    dft_engine #(
        .MAX_N (MAX_N)
    ) u_dft_engine (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .n_reg     (n_reg),
        .in_raddr  (in_raddr),
        .in_rdata  (in_rdata),
        .out_we    (out_we),
        .out_waddr (out_waddr),
        .out_wdata (out_wdata),
        .done      (done)
    );

    sample_ram #(
        .MAX_N (MAX_N)
    ) u_in_ram (                                // time-domain samples
        .clk   (clk),
        .we    (in_we),
        .waddr (in_addr),
        .wdata (in_wdata),
        .raddr (in_raddr),
        .rdata (in_rdata)
    );

    sample_ram #(
        .MAX_N (MAX_N)
    ) u_out_ram (                               // X[k] results
        .clk   (clk),
        .we    (out_we),
        .waddr (out_waddr),
        .wdata (out_wdata),
        .raddr (out_raddr),
        .rdata (out_rdata)
    );

endmodule

//--- verification/dft_checker.sv
// DFT output checker
// compares each result beat with the model queue and checks frame length,
// start right after done, error pulses and dft_ready around each frame
`timescale 1ns/100ps

module dft_checker
    import fp4_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  cfp4_t data_out,
    input  logic  data_out_valid,
    input  logic  dft_ready,
    input  logic  done,
    input  logic  error,
    input  logic  end_check,
    output int    errors,
    output int    beats
);

    cfp4_t exp_q [$];                           // expected X[k], all frames in order
    int    len_q [$];                           // N of every frame not yet streamed
    int    left;                                // beats still due in this frame
    int    bin;                                 // k of the next beat
    int    err_due;                             // rejected sizes still to answer
    logic  done_q, error_q, last_q;             // previous-edge copies
    logic  rst_seen, ended;
    cfp4_t exp;

    initial begin
        errors   = 0;
        beats    = 0;
        left     = 0;
        bin      = 0;
        err_due  = 0;
        done_q   = 1'b0;
        error_q  = 1'b0;
        last_q   = 1'b0;
        rst_seen = 1'b0;
        ended    = 1'b0;
    end

    task automatic add_frame(input int n);
        len_q.push_back(n);
    endtask

    task automatic add_result(input cfp4_t x);
        exp_q.push_back(x);
    endtask

    task automatic expect_error();
        err_due++;                              // one pulse per rejected beat
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("error at %0d ns: %s", $time, what);
    endtask

    always @(posedge clk) begin
        if (rst && !ended) begin
            if (!rst_seen && (!dft_ready || data_out_valid || done || error))
                note_failure("outputs are not idle after reset");
            rst_seen = 1'b1;
            if (error) begin
                if (err_due > 0)
                    err_due--;
                else
                    note_failure("error pulsed although n_points was valid");
            end
            if (error_q && !dft_ready)
                note_failure("dft_ready dropped after a rejected n_points"); // must stay idle
            if (last_q && !dft_ready)
                note_failure("dft_ready still low after the last output beat");
            if (done && len_q.size() == 0)
                note_failure("done pulsed with no frame loaded");
            if (done_q && len_q.size() != 0) begin  // frame opens right after done
                left = len_q.pop_front();
                bin  = 0;
                if (!data_out_valid)
                    note_failure("no output beat on the cycle after done");
            end
            last_q = 1'b0;
            if (data_out_valid) begin
                if (left == 0) begin
                    note_failure("output beat outside a frame");
                end else begin
                    exp = exp_q.pop_front();
                    beats++;
                    if (data_out !== exp) begin
                        errors++;
                        $display("mismatch at %0d ns: data_out X[%0d] got %h expected %h",
                                 $time, bin, data_out, exp);
                    end
                    if (dft_ready)
                        note_failure("dft_ready high while results stream out");
                    bin++;
                    left--;
                    last_q = (left == 0);
                end
            end else if (left != 0) begin
                note_failure("output frame ended before N beats");
                while (left != 0) begin         // drop the rest to stay aligned
                    exp = exp_q.pop_front();
                    left--;
                end
            end
            done_q  = done;
            error_q = error;
            if (end_check) begin
                ended = 1'b1;
                if (exp_q.size() != 0 || len_q.size() != 0)
                    note_failure("some expected results never came out");
                if (err_due != 0)
                    note_failure("a rejected n_points gave no error pulse");
            end
        end
    end

endmodule

//--- verification/tb_fp4_dft.sv
// testbench for the FP4 streaming DFT
// random and saturated frames for every valid N, rejected sizes, input gaps
// and stray valid beats while busy, predicted by a model built from E2M1 rules
`timescale 1ns/100ps

module tb_fp4_dft
    import fp4_pkg::*;
();

    localparam int          CYCLE_LIMIT = 20 * (32 * 32 + 100); // 20 frames at N = 32
    localparam logic [31:0] SEED        = 32'h1124;

    logic             clk;
    logic             rst;
    logic [CNT_W-1:0] n_points;
    cfp4_t            data_in;
    logic             data_in_valid;
    cfp4_t            data_out;
    logic             data_out_valid;
    logic             dft_ready;
    logic             done;
    logic             error;
    logic             end_check;
    int               errors;
    int               beats;
    int               cycles;
    int               frames;
    cfp4_t            frame_q [$];              // samples of the next frame

    fp4_dft #(
        .MAX_N (MAX_N)
    ) u_fp4_dft (
        .clk            (clk),
        .rst            (rst),
        .n_points       (n_points),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .dft_ready      (dft_ready),
        .done           (done),
        .error          (error)
    );

    dft_checker u_dft_checker (
        .clk            (clk),
        .rst            (rst),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .dft_ready      (dft_ready),
        .done           (done),
        .error          (error),
        .end_check      (end_check),
        .errors         (errors),
        .beats          (beats)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;                      // 20 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT never finished", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // E2M1 value in quarter units: e = 0 is m*0.5, else (1 + m/2) * 2^(e-1)
    function automatic int code_to_quarters(input logic [3:0] c);
        int e, m, mag;
        e = int'(c[2:1]);
        m = int'(c[0]);
        mag = (e == 0) ? 2 * m : (4 + 2 * m) << (e - 1);
        code_to_quarters = c[3] ? -mag : mag;
    endfunction

    // nearest magnitude, even code on a tie, nothing beyond 6, no -0
    function automatic logic [3:0] quarters_to_code(input int q);
        int mag, best, best_d, d;
        mag    = (q < 0) ? -q : q;
        best   = 0;
        best_d = mag;
        for (int c = 1; c < 8; c++) begin
            d = mag - code_to_quarters({1'b0, 3'(c)});
            if (d < 0)
                d = -d;
            if (d < best_d || (d == best_d && c % 2 == 0)) begin
                best   = c;
                best_d = d;
            end
        end
        quarters_to_code = {(q < 0) && (best != 0), best[2:0]};
    endfunction

    // quantized W^idx on the 32-point circle, quarters
    task automatic twiddle_quarters(input int idx, output int re, output int im);
        int t;
        case (idx % 8)
            0, 1:    begin re = 4; im = 0;  end
            2, 3:    begin re = 4; im = -2; end
            4:       begin re = 2; im = -2; end
            5, 6:    begin re = 2; im = -4; end
            default: begin re = 0; im = -4; end
        endcase
        for (int g = 0; g < idx / 8; g++) begin // times -j per octant pair
            t  = re;
            re = im;
            im = -t;
        end
    endtask

    task automatic predict_frame(input int n);
        int         idx, tr, ti, ar, ai;
        logic [3:0] p_re, p_im, s_re, s_im;
        cfp4_t      x;
        u_dft_checker.add_frame(n);
        for (int k = 0; k < n; k++) begin
            s_re = 4'd0;
            s_im = 4'd0;
            for (int j = 0; j < n; j++) begin
                x   = frame_q[j];
                idx = ((k * j) % n) * (MAX_N / n);
                twiddle_quarters(idx, tr, ti);
                ar   = code_to_quarters(x[7:4]);
                ai   = code_to_quarters(x[3:0]);
                p_re = quarters_to_code((ar * tr - ai * ti) / 4); // even operands, exact
                p_im = quarters_to_code((ar * ti + ai * tr) / 4);
                s_re = quarters_to_code(code_to_quarters(s_re) + code_to_quarters(p_re));
                s_im = quarters_to_code(code_to_quarters(s_im) + code_to_quarters(p_im));
            end
            u_dft_checker.add_result({s_re, s_im});
        end
    endtask

    task automatic random_frame(input int n);
        frame_q.delete();
        for (int j = 0; j < n; j++)
            frame_q.push_back(8'($urandom));
    endtask

    task automatic saturated_frame(input int n);
        logic [1:0] s;
        frame_q.delete();
        for (int j = 0; j < n; j++) begin
            s = 2'($urandom);                   // random sign per part
            frame_q.push_back({s[1], 3'b111, s[0], 3'b111});
        end
    endtask

    task automatic wait_ready();
        @(posedge clk);
        while (!dft_ready)
            @(posedge clk);
    endtask

    task automatic drive_stray();
        data_in_valid <= 1'($urandom % 2);
        data_in       <= 8'($urandom);
        n_points      <= CNT_W'($urandom % 64);
    endtask

    // junk beats through compute and all but the last output beat
    task automatic stray_beats(input int n);
        while (!done) begin
            drive_stray();
            @(posedge clk);
        end
        repeat (n - 1) begin
            drive_stray();
            @(posedge clk);
        end
        data_in_valid <= 1'b0;
    endtask

    task automatic run_frame(input int n, input bit gaps, input bit junk);
        int gap;
        predict_frame(n);
        frames++;
        wait_ready();
        for (int j = 0; j < n; j++) begin
            gap = gaps ? int'($urandom % 4) : 0;
            repeat (gap) begin
                data_in_valid <= 1'b0;
                data_in       <= 8'($urandom);
                @(posedge clk);
            end
            data_in_valid <= 1'b1;
            data_in       <= frame_q[j];
            n_points      <= CNT_W'(n);
            @(posedge clk);
        end
        data_in_valid <= 1'b0;
        if (junk)
            stray_beats(n);
    endtask

    task automatic reject_n(input int v);
        wait_ready();
        u_dft_checker.expect_error();
        data_in_valid <= 1'b1;
        data_in       <= 8'($urandom);
        n_points      <= CNT_W'(v);
        @(posedge clk);
        data_in_valid <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    initial begin
        void'($urandom(SEED));
        cycles        = 0;
        frames        = 0;
        rst           = 1'b0;
        n_points      = '0;
        data_in       = '0;
        data_in_valid = 1'b0;
        end_check     = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        for (int r = 0; r < 2; r++) begin       // second pass adds gaps and junk
            for (int s = 1; s <= 5; s++) begin
                random_frame(1 << s);
                run_frame(1 << s, r == 1, r == 1);
            end
        end
        reject_n(0);
        reject_n(3);
        reject_n(33);
        random_frame(8);
        run_frame(8, 1'b1, 1'b0);
        saturated_frame(8);
        run_frame(8, 1'b0, 1'b1);
        saturated_frame(32);
        run_frame(32, 1'b1, 1'b0);
        wait_ready();                           // last frame fully streamed
        repeat (4) @(posedge clk);
        end_check <= 1'b1;
        repeat (2) @(posedge clk);
        $display("frames %0d, beats compared %0d, errors %0d", frames, beats, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- list.f
verilog/fp4_pkg.sv
verilog/twiddle_rom.sv
verilog/fp4_cmul.sv
verilog/dft_mac.sv
verilog/sample_ram.sv
verilog/dft_engine.sv
verilog/stream_ctrl.sv
verilog/fp4_dft.sv
verification/dft_checker.sv
verification/tb_fp4_dft.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_fp4_dft
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Some tests failed
PASS_MSG = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation gave no result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)
